// File: verilog/sccb_pkg.sv
package sccb_pkg;

	//////////////////////////////////////////////////////////////////////
	// Link widths

	// Four 8b10b symbols per word, lane 0 first on the wire
	localparam int SYMBOL_WIDTH = 4;
	localparam int DATA_WIDTH = 8 * SYMBOL_WIDTH;
	localparam int ADDR_WIDTH = 32;

	// Byte count of one link word, 0 to 4
	localparam int NVALID_WIDTH = 3;

	// Credits returned per cycle, 0 to 2
	localparam int CREDIT_WIDTH = 2;

	//////////////////////////////////////////////////////////////////////
	// Symbol codes

	localparam logic [7:0] K_APB_WRITE = 8'hfb;	// K27.7
	localparam logic [7:0] K_APB_READ = 8'h1c;	// K28.0
	localparam logic [7:0] K_END = 8'hdc;		// K28.6
	localparam logic [7:0] K_IDLE = 8'hbc;		// K28.5

	// CRC-8, x^8 + x^2 + x + 1, zero seed
	localparam logic [7:0] CRC_POLY = 8'h07;

	// Consecutive idle words before the link counts as up
	localparam int LINK_UP_IDLES = 4;
	localparam int IDLE_CNT_WIDTH = $clog2(LINK_UP_IDLES);

	// One slot per sender credit
	localparam int QUEUE_DEPTH = 2;
	localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);
	localparam int QUEUE_CNT_WIDTH = $clog2(QUEUE_DEPTH + 1);

	//////////////////////////////////////////////////////////////////////
	// Enums

	typedef enum logic [1:0] {FRAME_WRITE, FRAME_READ, FRAME_OTHER} frame_type_t;

	typedef enum logic [1:0] {LINK_DOWN, LINK_IDLE, LINK_FRAME} link_state_t;

	typedef enum logic [1:0] {DEC_IDLE, DEC_ADDR, DEC_DATA, DEC_DONE} dec_state_t;

	typedef enum logic [1:0] {APB_IDLE, APB_SETUP, APB_ACCESS} apb_state_t;

endpackage

// File: verilog/sccb_rx_link.sv
`timescale 1ns/1ps

module sccb_rx_link (
	input  logic                                rx_clk,
	input  logic                                rst_n,
	input  logic [sccb_pkg::SYMBOL_WIDTH-1:0]   rx_kchar,
	input  logic [sccb_pkg::DATA_WIDTH-1:0]     rx_data,
	input  logic                                rx_data_valid,
	output logic                                ll_link_up,
	output logic                                ll_start,
	output logic                                ll_valid,
	output logic [sccb_pkg::NVALID_WIDTH-1:0]   ll_nvalid,
	output logic [sccb_pkg::DATA_WIDTH-1:0]     ll_data,
	output logic                                ll_commit,
	output logic                                ll_drop
);
	import sccb_pkg::*;

	link_state_t state;
	logic [IDLE_CNT_WIDTH-1:0] idle_cnt;
	logic [7:0] crc_q;
	logic [7:0] crc_next;
	logic [7:0] crc_rx;
	logic crc_match;
	logic end_ok;
	logic end_bad;
	logic word_idle;
	logic start_word;
	logic accept_word;
	logic has_end;
	logic [1:0] end_lane;
	logic [NVALID_WIDTH-1:0] nbytes;
	logic [SYMBOL_WIDTH-1:0] end_hit;
	logic [SYMBOL_WIDTH-1:0] data_mask;
	logic [SYMBOL_WIDTH-1:0] k_allowed;
	logic k_bad;
	logic [DATA_WIDTH-1:0] byte_mask;

	// Run the CRC over the first nbytes lanes, lane 0 first
	function automatic logic [7:0] crc8_word(input logic [7:0] crc_in,
		input logic [DATA_WIDTH-1:0] data, input logic [NVALID_WIDTH-1:0] nb);
		logic [7:0] c;
		c = crc_in;
		for (int i = 0; i < SYMBOL_WIDTH; i++) begin
			if (i < nb) begin
				c = c ^ data[8*i +: 8];
				for (int b = 0; b < 8; b++) begin
					c = c[7] ? ((c << 1) ^ CRC_POLY) : (c << 1);
				end
			end
		end
		return c;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Word classification

	always_comb begin
		word_idle = (rx_kchar == '1);
		for (int i = 0; i < SYMBOL_WIDTH; i++) begin
			if (rx_data[8*i +: 8] != K_IDLE)
				word_idle = 1'b0;
			end_hit[i] = rx_kchar[i] && (rx_data[8*i +: 8] == K_END);
		end

		// Lowest end marker wins
		// An end in the last lane has no room for the CRC, so it counts as a stray K
		has_end = 1'b0;
		end_lane = 2'd0;
		for (int i = SYMBOL_WIDTH - 2; i >= 0; i--) begin
			if (end_hit[i]) begin
				has_end = 1'b1;
				end_lane = 2'(i);
			end
		end
		nbytes = has_end ? NVALID_WIDTH'(end_lane) : NVALID_WIDTH'(SYMBOL_WIDTH);

		// Lanes below the end marker carry frame bytes
		for (int i = 0; i < SYMBOL_WIDTH; i++) begin
			data_mask[i] = (i < nbytes);
			byte_mask[8*i +: 8] = {8{data_mask[i]}};
		end

		// Any K lane other than the type byte is unknown
		start_word = (state == LINK_IDLE) && rx_kchar[0] &&
			(rx_data[7:0] != K_IDLE) && (rx_data[7:0] != K_END);
		k_allowed = {{(SYMBOL_WIDTH - 1){1'b0}}, start_word};
		k_bad = |(rx_kchar & data_mask & ~k_allowed);

		accept_word = rx_data_valid && !k_bad && (start_word || (state == LINK_FRAME));

		// CRC byte sits right after the end marker
		crc_rx = rx_data[8 * (int'(end_lane) + 1) +: 8];
		crc_next = crc8_word((state == LINK_FRAME) ? crc_q : 8'h00, rx_data, nbytes);
		crc_match = (crc_next == crc_rx);
	end

	//////////////////////////////////////////////////////////////////////
	// Link state and frame delimiting

	always_ff @(posedge rx_clk) begin
		if (!rst_n) begin
			state <= LINK_DOWN;
			idle_cnt <= '0;
			ll_start <= 1'b0;
			ll_valid <= 1'b0;
			ll_nvalid <= '0;
			end_ok <= 1'b0;
			end_bad <= 1'b0;
			ll_commit <= 1'b0;
			ll_drop <= 1'b0;
		end else begin
			ll_start <= 1'b0;
			ll_valid <= 1'b0;
			ll_nvalid <= '0;
			end_ok <= 1'b0;
			end_bad <= 1'b0;

			// Verdict goes out one cycle behind the last word
			ll_commit <= end_ok;
			ll_drop <= end_bad;

			if (accept_word) begin
				ll_start <= start_word;
				ll_valid <= 1'b1;
				ll_nvalid <= nbytes;
				if (has_end) begin
					end_ok <= crc_match;
					end_bad <= !crc_match;
				end
			end

			case (state)
				LINK_DOWN: begin
					if (rx_data_valid && word_idle) begin
						idle_cnt <= idle_cnt + 1'b1;
						if (idle_cnt == IDLE_CNT_WIDTH'(LINK_UP_IDLES - 1)) begin
							idle_cnt <= '0;
							state <= LINK_IDLE;
						end
					end else begin
						idle_cnt <= '0;
					end
				end

				LINK_IDLE: begin
					if (!rx_data_valid)
						state <= LINK_DOWN;
					else if (accept_word && !has_end)
						state <= LINK_FRAME;
				end

				LINK_FRAME: begin
					// Lost word or stray K ends the frame with a drop
					if (!rx_data_valid) begin
						end_bad <= 1'b1;
						state <= LINK_DOWN;
					end else if (k_bad) begin
						end_bad <= 1'b1;
						state <= LINK_IDLE;
					end else if (has_end) begin
						state <= LINK_IDLE;
					end
				end

				default: state <= LINK_DOWN;
			endcase
		end
	end

	// Running CRC and forwarded bytes, end marker and CRC masked off
	always_ff @(posedge rx_clk) begin
		crc_q <= crc_next;
		ll_data <= rx_data & byte_mask;
	end

	assign ll_link_up = (state != LINK_DOWN);

endmodule

// File: verilog/sccb_frame_decoder.sv
`timescale 1ns/1ps

module sccb_frame_decoder (
	input  logic                              rx_clk,
	input  logic                              rst_n,
	input  logic                              ll_link_up,
	input  logic                              ll_start,
	input  logic                              ll_valid,
	input  logic [sccb_pkg::DATA_WIDTH-1:0]   ll_data,
	input  logic                              ll_commit,
	input  logic                              ll_drop,
	output logic                              cmd_push,
	output logic [sccb_pkg::ADDR_WIDTH-1:0]   cmd_addr,
	output logic [sccb_pkg::DATA_WIDTH-1:0]   cmd_data,
	output logic                              write_refund
);
	import sccb_pkg::*;

	dec_state_t state;
	frame_type_t ftype;
	frame_type_t start_type;
	logic frame_done;
	logic [ADDR_WIDTH-1:0] addr_q;
	logic [DATA_WIDTH-1:0] data_q;

	// Type byte to frame class
	function automatic frame_type_t classify(input logic [7:0] type_byte);
		case (type_byte)
			K_APB_WRITE: return FRAME_WRITE;
			K_APB_READ: return FRAME_READ;
			default: return FRAME_OTHER;
		endcase
	endfunction

	assign start_type = classify(ll_data[7:0]);
	assign frame_done = (state == DEC_DONE);

	//////////////////////////////////////////////////////////////////////
	// Word sequencing

	// ftype outlives link-down so the late drop still sees the frame class
	always_ff @(posedge rx_clk) begin
		if (!rst_n) begin
			state <= DEC_IDLE;
			ftype <= FRAME_OTHER;
		end else begin
			if (ll_valid && ll_start) begin
				ftype <= start_type;
				// Reads and unknown types are only tracked until their verdict
				state <= (start_type == FRAME_WRITE) ? DEC_ADDR : DEC_IDLE;
			end else if (ll_commit || ll_drop) begin
				state <= DEC_IDLE;
			end else if (ll_valid) begin
				case (state)
					DEC_ADDR: state <= DEC_DATA;
					DEC_DATA: state <= DEC_DONE;
					// Extra word, frame too long
					default: state <= DEC_IDLE;
				endcase
			end

			if (!ll_link_up)
				state <= DEC_IDLE;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Address and data assembly

	// Wire order is big endian across lanes 0..3
	always_ff @(posedge rx_clk) begin
		if (ll_valid && ll_start) begin
			// Lane 1 is the sequence number, unused here
			addr_q[31:16] <= {ll_data[23:16], ll_data[31:24]};
		end else if (ll_valid && (state == DEC_ADDR)) begin
			addr_q[15:0] <= {ll_data[7:0], ll_data[15:8]};
			data_q[31:16] <= {ll_data[23:16], ll_data[31:24]};
		end else if (ll_valid && (state == DEC_DATA)) begin
			data_q[15:0] <= {ll_data[7:0], ll_data[15:8]};
		end
	end

	assign cmd_addr = addr_q;
	assign cmd_data = data_q;

	// Push lands in the commit cycle itself
	assign cmd_push = ll_commit && (ftype == FRAME_WRITE) && frame_done;

	// Sender spent a credit on any write frame, so give it back if nothing is queued
	assign write_refund = (ftype == FRAME_WRITE) && (ll_drop || (ll_commit && !frame_done));

endmodule

// File: verilog/sccb_cmd_queue.sv
`timescale 1ns/1ps

module sccb_cmd_queue (
	input  logic                                rx_clk,
	input  logic                                rst_n,
	input  logic                                cmd_push,
	input  logic [sccb_pkg::ADDR_WIDTH-1:0]     cmd_addr,
	input  logic [sccb_pkg::DATA_WIDTH-1:0]     cmd_data,
	input  logic                                cmd_pop,
	input  logic                                write_refund,
	output logic                                cmd_avail,
	output logic [sccb_pkg::ADDR_WIDTH-1:0]     q_addr,
	output logic [sccb_pkg::DATA_WIDTH-1:0]     q_data,
	output logic [sccb_pkg::CREDIT_WIDTH-1:0]   credit_return,
	output logic                                queue_overflow
);
	import sccb_pkg::*;

	logic [ADDR_WIDTH-1:0] addr_mem [QUEUE_DEPTH];
	logic [DATA_WIDTH-1:0] data_mem [QUEUE_DEPTH];
	logic [QUEUE_PTR_WIDTH-1:0] wr_ptr;
	logic [QUEUE_PTR_WIDTH-1:0] rd_ptr;
	logic [QUEUE_CNT_WIDTH-1:0] count;
	logic full;
	logic do_push;
	logic do_pop;

	function automatic logic [QUEUE_PTR_WIDTH-1:0] next_ptr(input logic [QUEUE_PTR_WIDTH-1:0] p);
		return (p == QUEUE_PTR_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full = (count == QUEUE_CNT_WIDTH'(QUEUE_DEPTH));
	assign do_pop = cmd_pop && (count != '0);
	// A pop in the same cycle frees the slot for the push
	assign do_push = cmd_push && (!full || do_pop);

	always_ff @(posedge rx_clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			queue_overflow <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// Sticky, sender pushed past its credits
			if (cmd_push && !do_push)
				queue_overflow <= 1'b1;
		end
	end

	always_ff @(posedge rx_clk) begin
		if (do_push) begin
			addr_mem[wr_ptr] <= cmd_addr;
			data_mem[wr_ptr] <= cmd_data;
		end
	end

	// Head entry straight from storage
	assign cmd_avail = (count != '0);
	assign q_addr = addr_mem[rd_ptr];
	assign q_data = data_mem[rd_ptr];

	// One credit per finished write, one per refunded frame
	assign credit_return = CREDIT_WIDTH'(cmd_pop) + CREDIT_WIDTH'(write_refund);

endmodule

// File: verilog/sccb_apb_requester.sv
`timescale 1ns/1ps

module sccb_apb_requester (
	input  logic                                  rx_clk,
	input  logic                                  rst_n,
	input  logic                                  cmd_avail,
	input  logic [sccb_pkg::ADDR_WIDTH-1:0]       q_addr,
	input  logic [sccb_pkg::DATA_WIDTH-1:0]       q_data,
	input  logic                                  pready,
	input  logic                                  pslverr,
	output logic                                  cmd_pop,
	output logic                                  psel,
	output logic [sccb_pkg::ADDR_WIDTH-1:0]       paddr,
	output logic [sccb_pkg::DATA_WIDTH-1:0]       pwdata,
	output logic                                  pwrite,
	output logic [sccb_pkg::SYMBOL_WIDTH-1:0]     pstrb,
	output logic                                  penable,
	output logic                                  slave_error
);
	import sccb_pkg::*;

	apb_state_t state;

	//////////////////////////////////////////////////////////////////////
	// APB handshake

	always_ff @(posedge rx_clk) begin
		if (!rst_n) begin
			state <= APB_IDLE;
			psel <= 1'b0;
			penable <= 1'b0;
			slave_error <= 1'b0;
		end else begin
			case (state)
				// Pick up the queue head
				APB_IDLE: begin
					if (cmd_avail) begin
						psel <= 1'b1;
						state <= APB_SETUP;
					end
				end

				// One setup cycle, then access
				APB_SETUP: begin
					penable <= 1'b1;
					state <= APB_ACCESS;
				end

				// Wait states as long as the completer wants
				APB_ACCESS: begin
					if (pready) begin
						psel <= 1'b0;
						penable <= 1'b0;
						state <= APB_IDLE;
						if (pslverr)
							slave_error <= 1'b1;
					end
				end

				default: state <= APB_IDLE;
			endcase
		end
	end

	// Address and data held from setup through completion
	always_ff @(posedge rx_clk) begin
		if ((state == APB_IDLE) && cmd_avail) begin
			paddr <= q_addr;
			pwdata <= q_data;
		end
	end

	// Completion frees the slot and returns the credit in the same cycle
	assign cmd_pop = (state == APB_ACCESS) && pready;

	// Writes only, full word
	assign pwrite = 1'b1;
	assign pstrb = '1;

endmodule

// File: verilog/sccb_rx_bridge.sv
`timescale 1ns/1ps

module sccb_rx_bridge (
	input  logic                                  rx_clk,
	input  logic                                  rst_n,
	input  logic [sccb_pkg::SYMBOL_WIDTH-1:0]     rx_kchar,
	input  logic [sccb_pkg::DATA_WIDTH-1:0]       rx_data,
	input  logic                                  rx_data_valid,
	output logic                                  psel,
	output logic                                  penable,
	output logic                                  pwrite,
	output logic [sccb_pkg::ADDR_WIDTH-1:0]       paddr,
	output logic [sccb_pkg::DATA_WIDTH-1:0]       pwdata,
	output logic [sccb_pkg::SYMBOL_WIDTH-1:0]     pstrb,
	input  logic                                  pready,
	input  logic                                  pslverr,
	output logic                                  slave_error,
	output logic [sccb_pkg::CREDIT_WIDTH-1:0]     credit_return,
	output logic                                  queue_overflow
);
	import sccb_pkg::*;

	// Link layer to decoder
	logic ll_link_up;
	logic ll_start;
	logic ll_valid;
	logic [DATA_WIDTH-1:0] ll_data;
	logic ll_commit;
	logic ll_drop;

	// Decoder to queue
	logic cmd_push;
	logic [ADDR_WIDTH-1:0] cmd_addr;
	logic [DATA_WIDTH-1:0] cmd_data;
	logic write_refund;

	// Queue to requester
	logic cmd_avail;
	logic cmd_pop;
	logic [ADDR_WIDTH-1:0] q_addr;
	logic [DATA_WIDTH-1:0] q_data;

	//////////////////////////////////////////////////////////////////////
	// Receive path

	// Byte count not needed, the decoder works on fixed word positions
	sccb_rx_link i_rx_link (
		.rx_clk(rx_clk), .rst_n(rst_n),
		.rx_kchar(rx_kchar), .rx_data(rx_data), .rx_data_valid(rx_data_valid),
		.ll_link_up(ll_link_up), .ll_start(ll_start), .ll_valid(ll_valid),
		.ll_nvalid(), .ll_data(ll_data), .ll_commit(ll_commit), .ll_drop(ll_drop)
	);

	sccb_frame_decoder i_frame_decoder (
		.rx_clk(rx_clk), .rst_n(rst_n),
		.ll_link_up(ll_link_up), .ll_start(ll_start), .ll_valid(ll_valid),
		.ll_data(ll_data), .ll_commit(ll_commit), .ll_drop(ll_drop),
		.cmd_push(cmd_push), .cmd_addr(cmd_addr), .cmd_data(cmd_data),
		.write_refund(write_refund)
	);

	sccb_cmd_queue i_cmd_queue (
		.rx_clk(rx_clk), .rst_n(rst_n),
		.cmd_push(cmd_push), .cmd_addr(cmd_addr), .cmd_data(cmd_data),
		.cmd_pop(cmd_pop), .write_refund(write_refund),
		.cmd_avail(cmd_avail), .q_addr(q_addr), .q_data(q_data),
		.credit_return(credit_return), .queue_overflow(queue_overflow)
	);

	sccb_apb_requester i_apb_requester (
		.rx_clk(rx_clk), .rst_n(rst_n),
		.cmd_avail(cmd_avail), .q_addr(q_addr), .q_data(q_data),
		.pready(pready), .pslverr(pslverr), .cmd_pop(cmd_pop),
		.psel(psel), .paddr(paddr), .pwdata(pwdata), .pwrite(pwrite),
		.pstrb(pstrb), .penable(penable), .slave_error(slave_error)
	);

endmodule

// File: tb/sccb_rx_bridge_asserts.sv
`timescale 1ns/1ps

module sccb_rx_bridge_asserts (
	input logic                                 rx_clk,
	input logic                                 rst_n,
	input logic                                 psel,
	input logic                                 penable,
	input logic [sccb_pkg::ADDR_WIDTH-1:0]      paddr,
	input logic                                 queue_overflow
);
	import sccb_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// APB handshake rules

	// Access phase only inside a selected transfer
	penable_needs_psel: assert property (@(posedge rx_clk) disable iff (!rst_n)
		penable |-> psel)
		else $error("penable high without psel");

	// Address held from setup to completion
	paddr_stable: assert property (@(posedge rx_clk) disable iff (!rst_n)
		($past(psel) && psel) |-> $stable(paddr))
		else $error("paddr changed while psel held");

	//////////////////////////////////////////////////////////////////////
	// Credit rule

	// Sender never exceeds its credits, so the queue never overflows
	no_overflow: assert property (@(posedge rx_clk) disable iff (!rst_n)
		!queue_overflow)
		else $error("queue_overflow raised");

endmodule

bind sccb_rx_bridge sccb_rx_bridge_asserts i_asserts (
	.rx_clk(rx_clk),
	.rst_n(rst_n),
	.psel(psel),
	.penable(penable),
	.paddr(paddr),
	.queue_overflow(queue_overflow)
);

// File: tb/tb_sccb_rx_bridge.sv
`timescale 1ns/1ps

module tb_sccb_rx_bridge;
	import sccb_pkg::*;

	localparam int TIMEOUT = 200;

	typedef enum {OUT_APB, OUT_NONE, OUT_REFUND} outcome_t;

	typedef struct {
		string name;
		frame_type_t ftype;
		logic [ADDR_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0] data;
		bit corrupt;
		bit abort;
		bit slverr;
		// Wait for completion before the next frame
		bit sync;
		outcome_t outcome;
	} entry_t;

	logic rx_clk = 1'b0;
	logic rst_n;
	logic [SYMBOL_WIDTH-1:0] rx_kchar;
	logic [DATA_WIDTH-1:0] rx_data;
	logic rx_data_valid;
	logic psel;
	logic penable;
	logic pwrite;
	logic [ADDR_WIDTH-1:0] paddr;
	logic [DATA_WIDTH-1:0] pwdata;
	logic [SYMBOL_WIDTH-1:0] pstrb;
	logic pready = 1'b0;
	logic pslverr = 1'b0;
	logic slave_error;
	logic [CREDIT_WIDTH-1:0] credit_return;
	logic queue_overflow;

	entry_t tbl[$];
	entry_t e;
	logic [ADDR_WIDTH-1:0] exp_addr[$];
	logic [DATA_WIDTH-1:0] exp_data[$];
	logic [ADDR_WIDTH-1:0] got_addr[$];
	logic [DATA_WIDTH-1:0] got_data[$];
	logic [SYMBOL_WIDTH-1:0] got_strb[$];
	logic got_write[$];
	int checked = 0;
	int errors = 0;
	int checks = 0;
	int spent = 0;
	int exp_total = 0;
	int returned_total = 0;
	int err_before;
	int wait_left = 0;
	logic err_mode = 1'b0;
	logic exp_slverr = 1'b0;

	sccb_rx_bridge i_dut (
		.rx_clk(rx_clk), .rst_n(rst_n),
		.rx_kchar(rx_kchar), .rx_data(rx_data), .rx_data_valid(rx_data_valid),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .pstrb(pstrb), .pready(pready), .pslverr(pslverr),
		.slave_error(slave_error), .credit_return(credit_return),
		.queue_overflow(queue_overflow)
	);

	always #5 rx_clk = ~rx_clk;

	//////////////////////////////////////////////////////////////////////
	// APB completer model and monitors

	// Random 0 to 3 wait states per transfer, chosen in setup
	always @(negedge rx_clk) begin
		pready = 1'b0;
		pslverr = 1'b0;
		if (rst_n && psel && !penable) begin
			wait_left = int'($urandom_range(3));
		end else if (rst_n && psel && penable) begin
			if (wait_left == 0) begin
				pready = 1'b1;
				pslverr = err_mode;
			end else begin
				wait_left--;
			end
		end
	end

	// Completed writes and returned credits
	always @(posedge rx_clk) begin
		if (rst_n) begin
			returned_total += int'(credit_return);
			if (psel && penable && pready) begin
				got_addr.push_back(paddr);
				got_data.push_back(pwdata);
				got_strb.push_back(pstrb);
				got_write.push_back(pwrite);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic check_apb_write(input logic [ADDR_WIDTH-1:0] ga,
		input logic [ADDR_WIDTH-1:0] ea, input logic [DATA_WIDTH-1:0] gd,
		input logic [DATA_WIDTH-1:0] ed, input logic [SYMBOL_WIDTH-1:0] gs,
		input logic [SYMBOL_WIDTH-1:0] es);
		checks++;
		if (ga !== ea || gd !== ed || gs !== es) begin
			$display("Fail %0t: APB write %h/%h strobe %b, expected %h/%h strobe %b",
				$time, ga, gd, gs, ea, ed, es);
			errors++;
		end
	endtask

	task automatic check_credits(input int got, input int exp, input string what);
		checks++;
		if (got != exp) begin
			$display("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Link stimulus

	// CRC-8 over the byte stream, MSB first, zero start
	function automatic logic [7:0] crc8(input logic [7:0] b[$]);
		logic [7:0] c;
		c = 8'h00;
		foreach (b[i]) begin
			c = c ^ b[i];
			repeat (8)
				c = c[7] ? ({c[6:0], 1'b0} ^ CRC_POLY) : {c[6:0], 1'b0};
		end
		return c;
	endfunction

	task automatic drive_word(input logic [SYMBOL_WIDTH-1:0] k,
		input logic [DATA_WIDTH-1:0] d, input logic v);
		@(negedge rx_clk);
		rx_kchar = k;
		rx_data = d;
		rx_data_valid = v;
	endtask

	task automatic drive_idle();
		drive_word('1, {SYMBOL_WIDTH{K_IDLE}}, 1'b1);
	endtask

	// Lane 0 first; K bits on the type byte and the end marker
	task automatic send_frame(input entry_t f, input int seq);
		logic [7:0] bytes[$];
		logic [7:0] tbyte;
		logic [7:0] crc;
		logic [DATA_WIDTH-1:0] w;
		logic [SYMBOL_WIDTH-1:0] k;
		int end_pos;
		int idx;
		case (f.ftype)
			FRAME_WRITE: tbyte = K_APB_WRITE;
			FRAME_READ: tbyte = K_APB_READ;
			// K28.1, not a known frame type
			default: tbyte = 8'h3c;
		endcase
		bytes = {tbyte, 8'(seq), f.addr[31:24], f.addr[23:16], f.addr[15:8], f.addr[7:0]};
		if (f.ftype == FRAME_WRITE)
			bytes = {bytes, f.data[31:24], f.data[23:16], f.data[15:8], f.data[7:0]};
		crc = crc8(bytes);
		if (f.corrupt)
			crc = crc ^ 8'h5a;
		end_pos = bytes.size();
		bytes.push_back(K_END);
		bytes.push_back(crc);
		for (int i = 0; i < bytes.size(); i += SYMBOL_WIDTH) begin
			for (int j = 0; j < SYMBOL_WIDTH; j++) begin
				idx = i + j;
				w[8*j +: 8] = bytes[idx];
				k[j] = (idx == 0) || (idx == end_pos);
			end
			// Abort replaces the last word with a gap in rx_data_valid
			if (f.abort && (i + SYMBOL_WIDTH >= bytes.size()))
				drive_word('0, '0, 1'b0);
			else
				drive_word(k, w, 1'b1);
		end
	endtask

	// Link must stay down until the last of LINK_UP_IDLES idles
	task automatic bring_up_link();
		for (int i = 0; i < LINK_UP_IDLES; i++) begin
			drive_idle();
			check_flag(i_dut.ll_link_up, 1'b0, "link up early");
		end
		drive_idle();
		check_flag(i_dut.ll_link_up, 1'b1, "link up");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Waits

	task automatic wait_for_credit();
		int n;
		n = 0;
		while (QUEUE_DEPTH - spent + returned_total <= 0) begin
			if (n == TIMEOUT) begin
				$display("Timeout: no credit came back from the bridge");
				errors++;
				return;
			end
			drive_idle();
			n++;
		end
	endtask

	task automatic wait_verdict();
		int n;
		n = 0;
		while (!(i_dut.ll_commit || i_dut.ll_drop)) begin
			if (n == TIMEOUT) begin
				$display("Timeout: link layer gave no commit or drop for the frame");
				errors++;
				return;
			end
			drive_idle();
			n++;
		end
	endtask

	// All expected writes seen, all credits back, bus idle
	task automatic wait_drained();
		int n;
		n = 0;
		while (got_addr.size() < exp_addr.size() || returned_total < exp_total || psel) begin
			if (n == TIMEOUT) begin
				$display("Timeout: APB writes or credits still outstanding");
				errors++;
				return;
			end
			drive_idle();
			n++;
		end
	endtask

	task automatic compare_writes();
		while (checked < exp_addr.size() && checked < got_addr.size()) begin
			// Full-word writes only
			check_apb_write(got_addr[checked], exp_addr[checked],
				got_data[checked], exp_data[checked], got_strb[checked], '1);
			check_flag(got_write[checked], 1'b1, "pwrite");
			checked++;
		end
		if (got_addr.size() != exp_addr.size()) begin
			$display("Fail %0t: %0d APB writes seen where %0d were expected",
				$time, got_addr.size(), exp_addr.size());
			errors++;
		end
	endtask

	task automatic add_entry(input string name, input frame_type_t ft, input bit corrupt,
		input bit abort, input bit slverr, input bit sync, input outcome_t outcome);
		entry_t t;
		t.name = name;
		t.ftype = ft;
		t.addr = $urandom;
		t.data = $urandom;
		t.corrupt = corrupt;
		t.abort = abort;
		t.slverr = slverr;
		t.sync = sync;
		t.outcome = outcome;
		tbl.push_back(t);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		rst_n = 1'b0;
		rx_kchar = '0;
		rx_data = '0;
		rx_data_valid = 1'b0;
		void'($urandom(32));

		add_entry("write", FRAME_WRITE, 0, 0, 0, 1, OUT_APB);
		add_entry("write again", FRAME_WRITE, 0, 0, 0, 1, OUT_APB);
		add_entry("bad crc", FRAME_WRITE, 1, 0, 0, 1, OUT_REFUND);
		add_entry("aborted write", FRAME_WRITE, 0, 1, 0, 1, OUT_REFUND);
		add_entry("read", FRAME_READ, 0, 0, 0, 1, OUT_NONE);
		add_entry("unknown type", FRAME_OTHER, 0, 0, 0, 1, OUT_NONE);
		// Back-to-back burst past the queue depth
		add_entry("burst 0", FRAME_WRITE, 0, 0, 0, 0, OUT_APB);
		add_entry("burst 1", FRAME_WRITE, 0, 0, 0, 0, OUT_APB);
		add_entry("burst 2", FRAME_WRITE, 0, 0, 0, 0, OUT_APB);
		add_entry("burst 3", FRAME_WRITE, 0, 0, 0, 1, OUT_APB);
		add_entry("slave error", FRAME_WRITE, 0, 0, 1, 1, OUT_APB);
		add_entry("write after error", FRAME_WRITE, 0, 0, 0, 1, OUT_APB);

		repeat (10) @(posedge rx_clk);
		@(negedge rx_clk);
		rst_n = 1'b1;
		check_flag(psel, 1'b0, "psel after reset");
		check_flag(penable, 1'b0, "penable after reset");
		check_flag(i_dut.ll_link_up, 1'b0, "link up after reset");
		check_credits(int'(credit_return), 0, "credit_return after reset");
		check_flag(queue_overflow, 1'b0, "queue_overflow after reset");

		// Test 0, write frame while the link is still down
		add_entry("pre-link", FRAME_WRITE, 0, 0, 0, 1, OUT_NONE);
		e = tbl.pop_back();
		send_frame(e, 0);
		bring_up_link();
		wait_drained();
		compare_writes();
		check_credits(returned_total, 0, "credits before link up");
		$display("Test 0 %s: %s", e.name, (errors == 0) ? "ok" : "FAILED");

		for (int i = 0; i < tbl.size(); i++) begin
			e = tbl[i];
			err_before = errors;
			if (e.ftype == FRAME_WRITE) begin
				wait_for_credit();
				spent++;
			end
			// A completed write or a refund both give the credit back
			if (e.outcome != OUT_NONE)
				exp_total++;
			if (e.outcome == OUT_APB) begin
				exp_addr.push_back(e.addr);
				exp_data.push_back(e.data);
			end
			err_mode = e.slverr;
			if (e.slverr)
				exp_slverr = 1'b1;

			send_frame(e, i + 1);
			// An abort takes the link down, so it has to come up again
			if (e.abort)
				bring_up_link();
			else if (e.sync)
				wait_verdict();

			if (e.sync) begin
				wait_drained();
				compare_writes();
				check_credits(returned_total, exp_total, "credits returned");
				check_flag(slave_error, exp_slverr, "slave_error");
				check_flag(queue_overflow, 1'b0, "queue_overflow");
			end
			drive_idle();
			drive_idle();
			$display("Test %0d %s: %s", i + 1, e.name,
				(errors == err_before) ? "ok" : "FAILED");
		end

		$display("Tests: %0d, checks: %0d, errors: %0d", tbl.size() + 1, checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// File: compile.f
verilog/sccb_pkg.sv
verilog/sccb_rx_link.sv
verilog/sccb_frame_decoder.sv
verilog/sccb_cmd_queue.sv
verilog/sccb_apb_requester.sv
verilog/sccb_rx_bridge.sv
tb/sccb_rx_bridge_asserts.sv
tb/tb_sccb_rx_bridge.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the receive bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
	--top-module tb_sccb_rx_bridge \
	--Mdir obj_dir -o sim_tb \
	-f compile.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Done: no errors" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
